// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := watch_periph_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/clock_timer.sv
`timescale 1ns/1ps

module clock_timer (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              restart,
  output periph_pkg::taps_t taps,
  output periph_pkg::taps_t tap_falls,
  output logic [3:0]        clock_event
);

  periph_pkg::presc_t prescaler;
  periph_pkg::taps_t  taps_prev;
  logic               tick;

  assign tick = prescaler == periph_pkg::presc_last;

  always_ff @(posedge clk) begin
    if (!reset_n || restart) begin
      prescaler <= '0;
      taps <= '0;
      taps_prev <= '0;
    end else begin
      prescaler <= tick ? '0 : prescaler + 1'b1;
      if (tick) begin
        taps <= taps + 1'b1;
      end
      taps_prev <= taps;
    end
  end

  // Cleared together on restart, so a restart shows no falls
  assign tap_falls = taps_prev & ~taps;

  // Falls of bits 2, 4, 6 and 7
  assign clock_event = {tap_falls[7], tap_falls[6], tap_falls[4], tap_falls[2]};

endmodule

// File: design/data_bus.sv
`timescale 1ns/1ps

module data_bus (
  input  logic                 clk,
  input  logic                 reset_n,
  input  io_map_pkg::mem_req_t bus,
  output io_map_pkg::io_req_t  io,
  input  io_map_pkg::nibble_t  io_read_data,
  output io_map_pkg::nibble_t  read_data
);

  io_map_pkg::nibble_t ram [0:io_map_pkg::ram_limit-1];
  io_map_pkg::nibble_t vram_low [0:io_map_pkg::vram_size-1];
  io_map_pkg::nibble_t vram_high [0:io_map_pkg::vram_size-1];

  logic                in_ram;
  logic                in_vram_low;
  logic                in_vram_high;
  logic                in_io;
  logic                read_strobe;
  logic [9:0]          ram_index;
  logic [6:0]          seg_index;
  io_map_pkg::nibble_t read_value;

  assign in_ram = bus.addr < io_map_pkg::ram_limit;
  assign in_vram_low = bus.addr >= io_map_pkg::vram_low_base &&
                       bus.addr < io_map_pkg::vram_low_base + io_map_pkg::vram_size;
  assign in_vram_high = bus.addr >= io_map_pkg::vram_high_base &&
                        bus.addr < io_map_pkg::vram_high_base + io_map_pkg::vram_size;
  assign in_io = bus.addr[11:8] == io_map_pkg::io_page;

  // A write wins over a read in the same cycle
  assign read_strobe = bus.read_en && !bus.write_en;

  // Segment bases are 128 aligned, so the low bits index the array
  assign ram_index = bus.addr[9:0];
  assign seg_index = bus.addr[6:0];

  assign io.write_en = bus.write_en && in_io;
  assign io.read_en = read_strobe && in_io;
  assign io.offset = bus.addr[7:0];
  assign io.write_data = bus.write_data;

  always_ff @(posedge clk) begin
    if (bus.write_en) begin
      if (in_ram) begin
        ram[ram_index] <= bus.write_data;
      end else if (in_vram_low) begin
        vram_low[seg_index] <= bus.write_data;
      end else if (in_vram_high) begin
        vram_high[seg_index] <= bus.write_data;
      end
    end
  end

  always_comb begin
    read_value = '0;
    if (in_ram) begin
      read_value = ram[ram_index];
    end else if (in_vram_low) begin
      read_value = vram_low[seg_index];
    end else if (in_vram_high) begin
      read_value = vram_high[seg_index];
    end else if (in_io) begin
      read_value = io_read_data;
    end
  end

  // Zero unless the previous cycle was a read
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      read_data <= '0;
    end else begin
      read_data <= read_strobe ? read_value : '0;
    end
  end

endmodule

// File: design/input_lines.sv
`timescale 1ns/1ps

module input_lines (
  input  logic                clk,
  input  logic                reset_n,
  input  io_map_pkg::nibble_t input_k0,
  input  io_map_pkg::nibble_t input_k1,
  input  periph_pkg::masks_t  masks,
  input  io_map_pkg::nibble_t relation_k0,
  output logic                k0_event,
  output logic                k1_event
);

  // Both ports share one chain, K1 in the upper half
  logic [7:0] sync_1;
  logic [7:0] sync_2;
  logic [7:0] prev;
  logic [3:0] rise;
  logic [7:0] fall;
  logic [3:0] k0_hit;
  logic [3:0] k1_hit;

  // Only K0 can trigger on a rising edge
  assign rise = sync_2[3:0] & ~prev[3:0];
  assign fall = ~sync_2 & prev;

  // Relation 1 selects the falling edge
  assign k0_hit = ((rise & ~relation_k0) | (fall[3:0] & relation_k0)) & masks.k0;
  assign k1_hit = fall[7:4] & masks.k1;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sync_1 <= '0;
      sync_2 <= '0;
      prev <= '0;
      k0_event <= 1'b0;
      k1_event <= 1'b0;
    end else begin
      sync_1 <= {input_k1, input_k0};
      sync_2 <= sync_1;
      prev <= sync_2;
      k0_event <= |k0_hit;
      k1_event <= |k1_hit;
    end
  end

endmodule

// File: design/interrupt_ctrl.sv
`timescale 1ns/1ps

module interrupt_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  periph_pkg::event_t   events,
  input  periph_pkg::clear_t   clear,
  input  periph_pkg::masks_t   masks,
  output periph_pkg::factors_t factors,
  output periph_pkg::irq_t     irq
);

  // Set has priority over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      factors <= '0;
    end else begin
      factors.clock <= events.clock | (factors.clock & ~clear.clock);
      factors.prog <= events.prog | (factors.prog & ~clear.prog);
      factors.k0 <= events.k0 | (factors.k0 & ~clear.k0);
      factors.k1 <= events.k1 | (factors.k1 & ~clear.k1);
    end
  end

  assign irq.clock = |(factors.clock & masks.clock);
  assign irq.prog = factors.prog & masks.prog;

  // Input factors were masked per bit before they set
  assign irq.k0 = factors.k0;
  assign irq.k1 = factors.k1;

endmodule

// File: design/io_map_pkg.sv
package io_map_pkg;

  typedef logic [11:0] addr_t;
  typedef logic [3:0] nibble_t;

  // Region bounds
  localparam addr_t ram_limit = 12'h280;
  localparam addr_t vram_low_base = 12'hE00;
  localparam addr_t vram_high_base = 12'hE80;
  localparam addr_t vram_size = 12'h050;
  localparam logic [3:0] io_page = 4'hF;

  // Offsets inside the I/O page
  typedef enum logic [7:0] {
    clock_factor   = 8'h00,
    prog_factor    = 8'h02,
    k0_factor      = 8'h04,
    k1_factor      = 8'h05,
    clock_mask     = 8'h10,
    prog_mask      = 8'h12,
    k0_mask        = 8'h14,
    k1_mask        = 8'h15,
    tmr_low        = 8'h20,
    tmr_high       = 8'h21,
    pt_count_low   = 8'h24,
    pt_count_high  = 8'h25,
    pt_reload_low  = 8'h26,
    pt_reload_high = 8'h27,
    k0_value       = 8'h40,
    k0_relation    = 8'h41,
    k1_value       = 8'h42,
    timer_reset    = 8'h76,
    pt_control     = 8'h78,
    pt_clock_sel   = 8'h79
  } io_reg_e;

  typedef struct packed {
    logic    write_en;
    logic    read_en;
    addr_t   addr;
    nibble_t write_data;
  } mem_req_t;

  typedef struct packed {
    logic       write_en;
    logic       read_en;
    logic [7:0] offset;
    nibble_t    write_data;
  } io_req_t;

endpackage

// File: design/io_regs.sv
`timescale 1ns/1ps

module io_regs (
  input  logic                 clk,
  input  logic                 reset_n,
  input  io_map_pkg::io_req_t  io,
  output io_map_pkg::nibble_t  io_read_data,
  input  periph_pkg::taps_t    taps,
  input  logic [7:0]           pt_count,
  input  periph_pkg::factors_t factors,
  input  io_map_pkg::nibble_t  input_k0,
  input  io_map_pkg::nibble_t  input_k1,
  output periph_pkg::masks_t   masks,
  output io_map_pkg::nibble_t  relation_k0,
  output periph_pkg::pt_ctrl_t pt_ctrl,
  output logic                 clock_restart,
  output periph_pkg::clear_t   clear
);

  io_map_pkg::io_reg_e reg_sel;
  logic [7:0]          reload;
  logic                pt_enable;
  logic                pt_restart;
  periph_pkg::pt_src_e clock_sel;

  assign reg_sel = io_map_pkg::io_reg_e'(io.offset);

  // Control registers
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      masks <= '0;
      relation_k0 <= '1;
      reload <= '0;
      pt_enable <= 1'b0;
      clock_sel <= periph_pkg::pt_src_off;
    end else if (io.write_en) begin
      case (reg_sel)
        io_map_pkg::clock_mask:     masks.clock <= io.write_data;
        io_map_pkg::prog_mask:      masks.prog <= io.write_data[0];
        io_map_pkg::k0_mask:        masks.k0 <= io.write_data;
        io_map_pkg::k1_mask:        masks.k1 <= io.write_data;
        io_map_pkg::pt_reload_low:  reload[3:0] <= io.write_data;
        io_map_pkg::pt_reload_high: reload[7:4] <= io.write_data;
        io_map_pkg::k0_relation:    relation_k0 <= io.write_data;
        io_map_pkg::pt_control:     pt_enable <= io.write_data[0];
        io_map_pkg::pt_clock_sel: begin
          clock_sel <= periph_pkg::pt_src_e'(io.write_data[2:0]);
        end
        default: ;
      endcase
    end
  end

  // Restart strobes act at the edge that samples the write
  assign clock_restart = io.write_en && reg_sel == io_map_pkg::timer_reset &&
                         io.write_data[1];
  assign pt_restart = io.write_en && reg_sel == io_map_pkg::pt_control &&
                      io.write_data[1];

  assign pt_ctrl.enable = pt_enable;
  assign pt_ctrl.restart = pt_restart;
  assign pt_ctrl.clock_sel = clock_sel;
  assign pt_ctrl.reload = reload;

  always_comb begin
    case (reg_sel)
      io_map_pkg::clock_factor:   io_read_data = factors.clock;
      io_map_pkg::prog_factor:    io_read_data = {3'b0, factors.prog};
      io_map_pkg::k0_factor:      io_read_data = {3'b0, factors.k0};
      io_map_pkg::k1_factor:      io_read_data = {3'b0, factors.k1};
      io_map_pkg::clock_mask:     io_read_data = masks.clock;
      io_map_pkg::prog_mask:      io_read_data = {3'b0, masks.prog};
      io_map_pkg::k0_mask:        io_read_data = masks.k0;
      io_map_pkg::k1_mask:        io_read_data = masks.k1;
      io_map_pkg::tmr_low:        io_read_data = taps[3:0];
      io_map_pkg::tmr_high:       io_read_data = taps[7:4];
      io_map_pkg::pt_count_low:   io_read_data = pt_count[3:0];
      io_map_pkg::pt_count_high:  io_read_data = pt_count[7:4];
      io_map_pkg::pt_reload_low:  io_read_data = reload[3:0];
      io_map_pkg::pt_reload_high: io_read_data = reload[7:4];
      io_map_pkg::k0_value:       io_read_data = input_k0;
      io_map_pkg::k0_relation:    io_read_data = relation_k0;
      io_map_pkg::k1_value:       io_read_data = input_k1;
      io_map_pkg::pt_control:     io_read_data = {3'b0, pt_enable};
      io_map_pkg::pt_clock_sel:   io_read_data = {1'b0, clock_sel};
      // timer_reset is write only
      default:                    io_read_data = '0;
    endcase
  end

  // Reading a factor register clears that factor
  always_comb begin
    clear = '0;
    if (io.read_en) begin
      case (reg_sel)
        io_map_pkg::clock_factor: clear.clock = '1;
        io_map_pkg::prog_factor:  clear.prog = 1'b1;
        io_map_pkg::k0_factor:    clear.k0 = 1'b1;
        io_map_pkg::k1_factor:    clear.k1 = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: design/periph_pkg.sv
package periph_pkg;

  // Clock timer prescaler
  localparam int clk_per_tick = 16;
  localparam int presc_width = $clog2(clk_per_tick);
  typedef logic [presc_width-1:0] presc_t;
  localparam presc_t presc_last = presc_t'(clk_per_tick - 1);

  typedef logic [7:0] taps_t;

  // Programmable timer source, code n selects counter bit n-1
  typedef enum logic [2:0] {
    pt_src_off = 3'd0,
    pt_src_b0  = 3'd1,
    pt_src_b1  = 3'd2,
    pt_src_b2  = 3'd3,
    pt_src_b3  = 3'd4,
    pt_src_b4  = 3'd5,
    pt_src_b5  = 3'd6,
    pt_src_b6  = 3'd7
  } pt_src_e;

  typedef struct packed {
    logic       enable;
    logic       restart;
    pt_src_e    clock_sel;
    logic [7:0] reload;
  } pt_ctrl_t;

  // Factor set pulses
  typedef struct packed {
    logic [3:0] clock;
    logic       prog;
    logic       k0;
    logic       k1;
  } event_t;

  // Factor clear pulses
  typedef struct packed {
    logic [3:0] clock;
    logic       prog;
    logic       k0;
    logic       k1;
  } clear_t;

  typedef struct packed {
    logic [3:0] clock;
    logic       prog;
    logic [3:0] k0;
    logic [3:0] k1;
  } masks_t;

  typedef struct packed {
    logic [3:0] clock;
    logic       prog;
    logic       k0;
    logic       k1;
  } factors_t;

  typedef struct packed {
    logic clock;
    logic prog;
    logic k0;
    logic k1;
  } irq_t;

endpackage

// File: design/prog_timer.sv
`timescale 1ns/1ps

module prog_timer (
  input  logic                 clk,
  input  logic                 reset_n,
  input  periph_pkg::pt_ctrl_t ctrl,
  input  periph_pkg::taps_t    tap_falls,
  output logic [7:0]           count,
  output logic                 prog_event
);

  logic src_fall;

  always_comb begin
    case (ctrl.clock_sel)
      periph_pkg::pt_src_b0: src_fall = tap_falls[0];
      periph_pkg::pt_src_b1: src_fall = tap_falls[1];
      periph_pkg::pt_src_b2: src_fall = tap_falls[2];
      periph_pkg::pt_src_b3: src_fall = tap_falls[3];
      periph_pkg::pt_src_b4: src_fall = tap_falls[4];
      periph_pkg::pt_src_b5: src_fall = tap_falls[5];
      periph_pkg::pt_src_b6: src_fall = tap_falls[6];
      default:               src_fall = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
      prog_event <= 1'b0;
    end else begin
      prog_event <= 1'b0;
      if (ctrl.restart) begin
        count <= ctrl.reload;
      end else if (ctrl.enable && src_fall) begin
        if (count == 8'd1) begin
          // Underflow raises the factor
          count <= '0;
          prog_event <= 1'b1;
        end else if (count == 8'd0) begin
          count <= ctrl.reload;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

// File: design/watch_periph_top.sv
`timescale 1ns/1ps

module watch_periph_top (
  input  logic                 clk,
  input  logic                 reset_n,
  input  io_map_pkg::mem_req_t bus,
  input  io_map_pkg::nibble_t  input_k0,
  input  io_map_pkg::nibble_t  input_k1,
  output io_map_pkg::nibble_t  read_data,
  output periph_pkg::irq_t     irq
);

  io_map_pkg::io_req_t  io;
  io_map_pkg::nibble_t  io_read_data;
  io_map_pkg::nibble_t  relation_k0;
  periph_pkg::taps_t    taps;
  periph_pkg::taps_t    tap_falls;
  periph_pkg::masks_t   masks;
  periph_pkg::pt_ctrl_t pt_ctrl;
  periph_pkg::clear_t   clear;
  periph_pkg::factors_t factors;
  periph_pkg::event_t   events;
  logic                 clock_restart;
  logic [7:0]           pt_count;

  data_bus data_bus0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus          (bus),
    .io           (io),
    .io_read_data (io_read_data),
    .read_data    (read_data)
  );

  io_regs io_regs0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .io            (io),
    .io_read_data  (io_read_data),
    .taps          (taps),
    .pt_count      (pt_count),
    .factors       (factors),
    .input_k0      (input_k0),
    .input_k1      (input_k1),
    .masks         (masks),
    .relation_k0   (relation_k0),
    .pt_ctrl       (pt_ctrl),
    .clock_restart (clock_restart),
    .clear         (clear)
  );

  clock_timer clock_timer0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .restart     (clock_restart),
    .taps        (taps),
    .tap_falls   (tap_falls),
    .clock_event (events.clock)
  );

  prog_timer prog_timer0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .ctrl       (pt_ctrl),
    .tap_falls  (tap_falls),
    .count      (pt_count),
    .prog_event (events.prog)
  );

  input_lines input_lines0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .input_k0    (input_k0),
    .input_k1    (input_k1),
    .masks       (masks),
    .relation_k0 (relation_k0),
    .k0_event    (events.k0),
    .k1_event    (events.k1)
  );

  interrupt_ctrl interrupt_ctrl0 (
    .clk     (clk),
    .reset_n (reset_n),
    .events  (events),
    .clear   (clear),
    .masks   (masks),
    .factors (factors),
    .irq     (irq)
  );

endmodule

// File: filelist.f
design/io_map_pkg.sv
design/periph_pkg.sv
design/data_bus.sv
design/io_regs.sv
design/clock_timer.sv
design/prog_timer.sv
design/input_lines.sv
design/interrupt_ctrl.sv
design/watch_periph_top.sv
test/watch_periph_tb.sv

// File: test/watch_periph_tb.sv
`timescale 1ns/1ps

module watch_periph_tb;

  localparam int clk_per_tick = periph_pkg::clk_per_tick;
  localparam int max_tick_wait = 4000;
  localparam int tick_trials = 4;
  localparam int clock_irq_limit = 8 * clk_per_tick * 2;
  localparam int max_reload = 40;
  localparam int prog_limit = (max_reload + 1) * 2 * clk_per_tick + 64;
  localparam int bus_budget = 10000;
  localparam int watchdog_cycles =
    2 * (tick_trials * max_tick_wait + clock_irq_limit + prog_limit + bus_budget);

  // Registers with a read-back path
  localparam io_map_pkg::io_reg_e rw_regs [8] = '{
    io_map_pkg::clock_mask, io_map_pkg::prog_mask, io_map_pkg::k0_mask,
    io_map_pkg::k1_mask, io_map_pkg::pt_reload_low, io_map_pkg::pt_reload_high,
    io_map_pkg::k0_relation, io_map_pkg::pt_clock_sel
  };

  logic                 clk = 1'b0;
  logic                 reset_n;
  io_map_pkg::mem_req_t bus;
  io_map_pkg::nibble_t  input_k0;
  io_map_pkg::nibble_t  input_k1;
  io_map_pkg::nibble_t  read_data;
  periph_pkg::irq_t     irq;

  io_map_pkg::nibble_t model [io_map_pkg::addr_t];
  int unsigned         cycle_count;

  watch_periph_top dut0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus       (bus),
    .input_k0  (input_k0),
    .input_k1  (input_k1),
    .read_data (read_data),
    .irq       (irq)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  function automatic io_map_pkg::addr_t io_addr(input io_map_pkg::io_reg_e r);
    return {io_map_pkg::io_page, 8'(r)};
  endfunction

  // Defined bits of each read-back register
  function automatic io_map_pkg::nibble_t reg_width(input io_map_pkg::io_reg_e r);
    case (r)
      io_map_pkg::prog_mask:    reg_width = 4'b0001;
      io_map_pkg::pt_clock_sel: reg_width = 4'b0111;
      default:                  reg_width = 4'b1111;
    endcase
  endfunction

  // Kind 0 to 2 are the mapped regions, anything else is unmapped
  function automatic io_map_pkg::addr_t pick_addr(input int kind);
    case (kind)
      0: pick_addr = io_map_pkg::addr_t'($urandom_range(32'h27F, 0));
      1: pick_addr = io_map_pkg::addr_t'(32'hE00 + $urandom_range(32'h4F, 0));
      2: pick_addr = io_map_pkg::addr_t'(32'hE80 + $urandom_range(32'h4F, 0));
      default: begin
        case ($urandom_range(2, 0))
          0: pick_addr = io_map_pkg::addr_t'($urandom_range(32'hDFF, 32'h280));
          1: pick_addr = io_map_pkg::addr_t'($urandom_range(32'hE7F, 32'hE50));
          default: pick_addr = io_map_pkg::addr_t'($urandom_range(32'hEFF, 32'hED0));
        endcase
      end
    endcase
  endfunction

  // Counter may lag the cycle count by one tick
  function automatic bit nibble_near(input io_map_pkg::nibble_t got,
                                     input int unsigned ticks, input int nib);
    logic [7:0] now;
    logic [7:0] earlier;
    now = 8'(ticks);
    earlier = 8'(ticks - 1);
    return got == now[nib*4 +: 4] || got == earlier[nib*4 +: 4];
  endfunction

  task automatic write_word(input io_map_pkg::addr_t addr, input io_map_pkg::nibble_t data);
    @(negedge clk);
    assert (read_data == 4'h0)
      else stop_on_error($sformatf("read_data %h in a cycle without a read", read_data));
    bus = '{write_en: 1'b1, read_en: 1'b0, addr: addr, write_data: data};
    @(negedge clk);
    bus = '0;
  endtask

  task automatic read_word(input io_map_pkg::addr_t addr, output io_map_pkg::nibble_t data);
    @(negedge clk);
    assert (read_data == 4'h0)
      else stop_on_error($sformatf("read_data %h in a cycle without a read", read_data));
    bus = '{write_en: 1'b0, read_en: 1'b1, addr: addr, write_data: 4'h0};
    @(negedge clk);
    bus = '0;
    data = read_data;
  endtask

  task automatic read_expect(input io_map_pkg::addr_t addr, input io_map_pkg::nibble_t exp,
                             input string what);
    io_map_pkg::nibble_t got;
    read_word(addr, got);
    assert (got == exp)
      else stop_on_error($sformatf("%s at %h read %h, expected %h", what, addr, got, exp));
  endtask

  task automatic check_reset_values();
    assert (irq == '0) else stop_on_error("irq not zero after reset");
    read_expect(io_addr(io_map_pkg::k0_relation), 4'hF, "k0_relation after reset");
    read_expect(io_addr(io_map_pkg::clock_mask), 4'h0, "clock_mask after reset");
    read_expect(io_addr(io_map_pkg::pt_clock_sel), 4'h0, "pt_clock_sel after reset");
    read_expect(io_addr(io_map_pkg::pt_reload_low), 4'h0, "pt_reload_low after reset");
  endtask

  task automatic check_memory();
    io_map_pkg::addr_t   addr;
    io_map_pkg::nibble_t data;
    int                  kind;
    for (int i = 0; i < 300; i++) begin
      kind = $urandom_range(3, 0);
      addr = pick_addr(kind);
      if (kind == 3) begin
        if ($urandom_range(1, 0) == 1) begin
          write_word(addr, 4'($urandom));
        end else begin
          read_expect(addr, 4'h0, "unmapped read");
        end
      end else if (model.exists(addr) && $urandom_range(1, 0) == 1) begin
        read_expect(addr, model[addr], "memory read");
      end else begin
        data = 4'($urandom);
        write_word(addr, data);
        model[addr] = data;
      end
    end
    foreach (model[a]) begin
      read_expect(a, model[a], "memory read back");
    end
  endtask

  task automatic check_registers();
    io_map_pkg::nibble_t data;
    for (int round = 0; round < 6; round++) begin
      foreach (rw_regs[i]) begin
        data = 4'($urandom);
        write_word(io_addr(rw_regs[i]), data);
        read_expect(io_addr(rw_regs[i]), data & reg_width(rw_regs[i]), "register read back");
      end
    end
    // Quiet all interrupt sources again
    write_word(io_addr(io_map_pkg::clock_mask), 4'h0);
    write_word(io_addr(io_map_pkg::prog_mask), 4'h0);
    write_word(io_addr(io_map_pkg::k0_mask), 4'h0);
    write_word(io_addr(io_map_pkg::k1_mask), 4'h0);
  endtask

  task automatic check_clock_timer();
    io_map_pkg::nibble_t low;
    io_map_pkg::nibble_t high;
    int unsigned         start;
    for (int t = 0; t < tick_trials; t++) begin
      write_word(io_addr(io_map_pkg::timer_reset), 4'b0010);
      start = cycle_count;
      repeat ($urandom_range(max_tick_wait - 100, 20)) @(negedge clk);
      read_word(io_addr(io_map_pkg::tmr_low), low);
      assert (nibble_near(low, (cycle_count - start) / clk_per_tick, 0))
        else stop_on_error($sformatf("tmr_low %h after %0d cycles", low, cycle_count - start));
      read_word(io_addr(io_map_pkg::tmr_high), high);
      assert (nibble_near(high, (cycle_count - start) / clk_per_tick, 1))
        else stop_on_error($sformatf("tmr_high %h after %0d cycles", high, cycle_count - start));
    end
  endtask

  task automatic check_clock_irq();
    io_map_pkg::nibble_t got;
    int                  waited;
    write_word(io_addr(io_map_pkg::clock_mask), 4'h0);
    write_word(io_addr(io_map_pkg::timer_reset), 4'b0010);
    // Drop factors left from earlier tests
    read_word(io_addr(io_map_pkg::clock_factor), got);
    write_word(io_addr(io_map_pkg::clock_mask), 4'b0001);
    assert (!irq.clock) else stop_on_error("irq.clock high right after a restart");
    waited = 0;
    while (!irq.clock && waited < clock_irq_limit) begin
      @(negedge clk);
      waited++;
    end
    assert (irq.clock) else stop_on_error("irq.clock did not rise after a restart");
    read_word(io_addr(io_map_pkg::clock_factor), got);
    assert (got != 4'h0) else stop_on_error("clock_factor read zero with irq.clock high");
    assert (!irq.clock) else stop_on_error("irq.clock still high after clock_factor read");
    write_word(io_addr(io_map_pkg::clock_mask), 4'h0);
  endtask

  task automatic check_prog_timer();
    io_map_pkg::nibble_t got;
    logic [7:0]          reload;
    logic [7:0]          prev;
    int                  waited;
    reload = 8'($urandom_range(max_reload, 3));
    write_word(io_addr(io_map_pkg::pt_control), 4'h0);
    write_word(io_addr(io_map_pkg::pt_clock_sel), 4'(periph_pkg::pt_src_b0));
    write_word(io_addr(io_map_pkg::pt_reload_low), reload[3:0]);
    write_word(io_addr(io_map_pkg::pt_reload_high), reload[7:4]);
    write_word(io_addr(io_map_pkg::prog_mask), 4'h1);
    read_word(io_addr(io_map_pkg::prog_factor), got);
    // Enable and restart in one write
    write_word(io_addr(io_map_pkg::pt_control), 4'b0011);
    prev = reload;
    waited = 0;
    while (!irq.prog && waited < (reload + 1) * 2 * clk_per_tick + 64) begin
      @(negedge clk);
      assert (dut0.pt_count <= prev || dut0.pt_count == reload)
        else stop_on_error($sformatf("pt_count rose from %0d to %0d", prev, dut0.pt_count));
      prev = dut0.pt_count;
      waited++;
    end
    assert (irq.prog) else stop_on_error($sformatf("irq.prog missing for reload %0d", reload));
    read_expect(io_addr(io_map_pkg::prog_factor), 4'h1, "prog_factor");
    assert (!irq.prog) else stop_on_error("irq.prog still high after prog_factor read");
    read_expect(io_addr(io_map_pkg::prog_factor), 4'h0, "prog_factor after clear");
    write_word(io_addr(io_map_pkg::pt_control), 4'h0);
    write_word(io_addr(io_map_pkg::prog_mask), 4'h0);
  endtask

  task automatic check_inputs();
    io_map_pkg::nibble_t got;
    io_map_pkg::nibble_t mask0;
    io_map_pkg::nibble_t mask1;
    io_map_pkg::nibble_t relation;
    int                  bit_sel;
    logic                k0_exp;
    logic                k1_exp;
    read_word(io_addr(io_map_pkg::k0_factor), got);
    read_word(io_addr(io_map_pkg::k1_factor), got);
    for (int round = 0; round < 3; round++) begin
      mask0 = 4'($urandom);
      mask1 = 4'($urandom);
      relation = 4'($urandom);
      write_word(io_addr(io_map_pkg::k0_mask), mask0);
      write_word(io_addr(io_map_pkg::k1_mask), mask1);
      write_word(io_addr(io_map_pkg::k0_relation), relation);
      for (int i = 0; i < 10; i++) begin
        bit_sel = $urandom_range(3, 0);
        @(negedge clk);
        if ($urandom_range(1, 0) == 0) begin
          input_k0[bit_sel] = ~input_k0[bit_sel];
          // Relation 0 wants a rising edge, relation 1 a falling one
          k0_exp = mask0[bit_sel] && (input_k0[bit_sel] != relation[bit_sel]);
          k1_exp = 1'b0;
        end else begin
          input_k1[bit_sel] = ~input_k1[bit_sel];
          k0_exp = 1'b0;
          k1_exp = mask1[bit_sel] && !input_k1[bit_sel];
        end
        repeat (5) @(negedge clk);
        assert (irq.k0 == k0_exp && irq.k1 == k1_exp)
          else stop_on_error($sformatf("irq k0 %b k1 %b, expected %b %b",
                                       irq.k0, irq.k1, k0_exp, k1_exp));
        read_expect(io_addr(io_map_pkg::k0_factor), {3'b0, k0_exp}, "k0_factor");
        read_expect(io_addr(io_map_pkg::k1_factor), {3'b0, k1_exp}, "k1_factor");
      end
    end
  endtask

  initial begin
    void'($urandom(32'h3b3b9a5b));
    reset_n = 1'b0;
    bus = '0;
    input_k0 = 4'h0;
    input_k1 = 4'h0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    check_reset_values();
    check_memory();
    check_registers();
    check_clock_timer();
    check_clock_irq();
    check_prog_timer();
    check_inputs();
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout, the tests did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
